// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - src/exu_pkg.sv
  - src/alu.sv
  - src/branch_cond.sv
  - src/imm_decode.sv
  - src/alu_fu.sv
  - src/issue_dispatch.sv
  - src/cdb_arbiter.sv
  - src/exec_cluster.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/exec_cluster_tb.sv

// ==== compile.f ====
src/exu_pkg.sv
src/alu.sv
src/branch_cond.sv
src/imm_decode.sv
src/alu_fu.sv
src/issue_dispatch.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
test/tb_clock_gen.sv
test/exec_cluster_tb.sv

// ==== src/alu.sv ====
// combinational rv32 integer alu for the ten register and immediate operations
`timescale 1ns/1ps

module alu (
    input  logic [exu_pkg::xlen-1:0] opa,
    input  logic [exu_pkg::xlen-1:0] opb,
    input  exu_pkg::alu_func_t       func,
    output logic [exu_pkg::xlen-1:0] result
);

    // signed views for slt and sra
    logic signed [exu_pkg::xlen-1:0] opa_s;
    logic signed [exu_pkg::xlen-1:0] opb_s;
    // shift amount, low five bits only
    logic [4:0]                      shamt;

    assign opa_s = opa;
    assign opb_s = opb;
    assign shamt = opb[4:0];

    always_comb begin
        case (func)
            exu_pkg::alu_add:  result = opa + opb;
            exu_pkg::alu_sub:  result = opa - opb;
            exu_pkg::alu_and:  result = opa & opb;
            exu_pkg::alu_or:   result = opa | opb;
            exu_pkg::alu_xor:  result = opa ^ opb;
            // set-less-than results are zero extended
            exu_pkg::alu_slt:  result = {{(exu_pkg::xlen-1){1'b0}}, (opa_s < opb_s)};
            exu_pkg::alu_sltu: result = {{(exu_pkg::xlen-1){1'b0}}, (opa < opb)};
            exu_pkg::alu_sll:  result = opa << shamt;
            exu_pkg::alu_srl:  result = opa >> shamt;
            // arithmetic shift keeps the sign
            exu_pkg::alu_sra:  result = opa_s >>> shamt;
            // undefined code, visible marker
            default:           result = 32'hbadc_0de5;
        endcase
    end

endmodule

// ==== src/alu_fu.sv ====
// alu functional unit with operand muxes, branch resolution and a held result
`timescale 1ns/1ps

module alu_fu (
    input  logic                clock,
    input  logic                reset,
    input  logic                fu_valid,
    input  exu_pkg::fu_in_t     fu_op,
    input  logic                cdb_ack,
    output exu_pkg::fu_result_t result
);

    logic [exu_pkg::xlen-1:0] opa;
    logic [exu_pkg::xlen-1:0] opb;
    logic [exu_pkg::xlen-1:0] imm;
    logic [exu_pkg::xlen-1:0] alu_result;
    logic                     cond_take;
    logic                     take_branch;
    exu_pkg::inst_r_t         inst_f;

    // field view of the instruction word
    assign inst_f = exu_pkg::inst_r_t'(fu_op.inst);

    // operand a
    always_comb begin
        case (fu_op.opa_sel)
            exu_pkg::opa_rs1: opa = fu_op.rs1_value;
            exu_pkg::opa_npc: opa = fu_op.npc;
            exu_pkg::opa_pc:  opa = fu_op.pc;
            default:          opa = '0;
        endcase
    end

    imm_decode imm_decode_0 (
        .inst    (fu_op.inst),
        .opb_sel (fu_op.opb_sel),
        .imm     (imm)
    );

    // operand b from rs2 or the already decoded immediate
    assign opb = (fu_op.opb_sel == exu_pkg::opb_rs2) ? fu_op.rs2_value : imm;

    alu alu_0 (
        .opa    (opa),
        .opb    (opb),
        .func   (fu_op.alu_func),
        .result (alu_result)
    );

    // compare always runs on the register values
    branch_cond branch_cond_0 (
        .funct3 (inst_f.funct3),
        .rs1    (fu_op.rs1_value),
        .rs2    (fu_op.rs2_value),
        .take   (cond_take)
    );

    // jumps always taken and branches only when the condition holds
    assign take_branch = fu_op.uncond_branch | (fu_op.cond_branch & cond_take);

    // ack clears done ahead of any new capture
    // payload held until the next issue to this unit
    always_ff @(posedge clock) begin
        if (reset) begin
            result.done <= 1'b0;
        end else if (cdb_ack) begin
            result.done <= 1'b0;
        end else if (fu_valid) begin
            result.done          <= 1'b1;
            // taken branch writes the link address
            result.value         <= take_branch ? fu_op.npc : alu_result;
            result.branch_target <= alu_result;
            result.take_branch   <= take_branch;
            result.rob_tag       <= fu_op.rob_tag;
        end
    end

endmodule

// ==== src/branch_cond.sv ====
// conditional branch evaluator for the six rv32 compare-and-branch codes
`timescale 1ns/1ps

module branch_cond (
    input  logic [2:0]               funct3,
    input  logic [exu_pkg::xlen-1:0] rs1,
    input  logic [exu_pkg::xlen-1:0] rs2,
    output logic                     take
);

    logic signed [exu_pkg::xlen-1:0] rs1_s;
    logic signed [exu_pkg::xlen-1:0] rs2_s;

    assign rs1_s = rs1;
    assign rs2_s = rs2;

    always_comb begin
        case (funct3)
            exu_pkg::f3_beq:  take = (rs1 == rs2);
            exu_pkg::f3_bne:  take = (rs1 != rs2);
            // signed compares
            exu_pkg::f3_blt:  take = (rs1_s < rs2_s);
            exu_pkg::f3_bge:  take = (rs1_s >= rs2_s);
            // unsigned compares
            exu_pkg::f3_bltu: take = (rs1 < rs2);
            exu_pkg::f3_bgeu: take = (rs1 >= rs2);
            // reserved codes never branch
            default:          take = 1'b0;
        endcase
    end

endmodule

// ==== src/cdb_arbiter.sv ====
// round-robin data bus arbiter, broadcasts one completed unit result per cycle
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int NUM_FU = 2
) (
    input  logic                clock,
    input  logic                reset,
    input  exu_pkg::fu_result_t fu_result [NUM_FU],
    output logic [NUM_FU-1:0]   cdb_ack,
    output exu_pkg::cdb_t       cdb
);

    localparam int PTR_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

    logic [PTR_W-1:0]         ptr;
    logic [PTR_W-1:0]         win;
    logic                     any_grant;
    // registered broadcast fields
    logic                     bus_valid;
    exu_pkg::rob_tag_t        bus_tag;
    logic [exu_pkg::xlen-1:0] bus_value;
    logic                     bus_take;
    logic [exu_pkg::xlen-1:0] bus_target;

    // first done unit at or after the pointer
    always_comb begin
        int idx;
        cdb_ack   = '0;
        win       = '0;
        any_grant = 1'b0;
        for (int k = 0; k < NUM_FU; k++) begin
            idx = int'(ptr) + k;
            if (idx >= NUM_FU) idx = idx - NUM_FU;
            if (fu_result[idx].done && !any_grant) begin
                any_grant    = 1'b1;
                win          = PTR_W'(idx);
                cdb_ack[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus_valid <= 1'b0;
            ptr       <= '0;
        end else begin
            bus_valid <= any_grant;
            // move past the winner, wrap at the last unit
            if (any_grant) begin
                ptr <= (int'(win) == NUM_FU - 1) ? '0 : win + 1'b1;
            end
        end
    end

    // winner payload, only meaningful with valid high
    always_ff @(posedge clock) begin
        if (any_grant) begin
            bus_tag    <= fu_result[win].rob_tag;
            bus_value  <= fu_result[win].value;
            bus_take   <= fu_result[win].take_branch;
            bus_target <= fu_result[win].branch_target;
        end
    end

    assign cdb = '{
        valid:         bus_valid,
        rob_tag:       bus_tag,
        value:         bus_value,
        take_branch:   bus_take,
        branch_target: bus_target
    };

endmodule

// ==== src/exec_cluster.sv ====
// integer execute cluster top: dispatcher, alu units and data bus arbiter
`timescale 1ns/1ps

module exec_cluster #(
    parameter int NUM_FU = 2
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            issue_req,
    input  exu_pkg::fu_in_t issue_op,
    output logic            issue_ack,
    output exu_pkg::cdb_t   cdb
);

    logic [NUM_FU-1:0]   fu_valid;
    logic [NUM_FU-1:0]   fu_done;
    logic [NUM_FU-1:0]   cdb_ack;
    exu_pkg::fu_in_t     fu_op;
    exu_pkg::fu_result_t fu_result [NUM_FU];

    issue_dispatch #(
        .NUM_FU (NUM_FU)
    ) issue_dispatch_0 (
        .clock     (clock),
        .reset     (reset),
        .issue_req (issue_req),
        .issue_op  (issue_op),
        .issue_ack (issue_ack),
        .fu_done   (fu_done),
        .fu_valid  (fu_valid),
        .fu_op     (fu_op)
    );

    // one alu unit per slot, all see the same operation register
    for (genvar i = 0; i < NUM_FU; i++) begin : g_fu
        alu_fu alu_fu_i (
            .clock    (clock),
            .reset    (reset),
            .fu_valid (fu_valid[i]),
            .fu_op    (fu_op),
            .cdb_ack  (cdb_ack[i]),
            .result   (fu_result[i])
        );
        // busy flag back to the dispatcher
        assign fu_done[i] = fu_result[i].done;
    end

    cdb_arbiter #(
        .NUM_FU (NUM_FU)
    ) cdb_arbiter_0 (
        .clock     (clock),
        .reset     (reset),
        .fu_result (fu_result),
        .cdb_ack   (cdb_ack),
        .cdb       (cdb)
    );

endmodule

// ==== src/exu_pkg.sv ====
// integer execute cluster shared types: alu codes, operand selects, packets
package exu_pkg;

    // datapath width
    localparam int xlen = 32;

    // alu operation codes
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5,
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_t;

    // operand a sources
    typedef enum logic [1:0] {
        opa_rs1  = 2'h0,
        opa_npc  = 2'h1,
        opa_pc   = 2'h2,
        opa_zero = 2'h3
    } opa_sel_t;

    // operand b sources, register or one of the immediate formats
    typedef enum logic [2:0] {
        opb_rs2   = 3'h0,
        opb_i_imm = 3'h1,
        opb_s_imm = 3'h2,
        opb_b_imm = 3'h3,
        opb_u_imm = 3'h4,
        opb_j_imm = 3'h5
    } opb_sel_t;

    // r-type field layout, funct3 sits in the same place for branches
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // branch funct3 codes
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef logic [5:0] rob_tag_t;

    // one issued operation
    typedef struct packed {
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        opa_sel_t        opa_sel;
        opb_sel_t        opb_sel;
        alu_func_t       alu_func;
        logic            cond_branch;
        logic            uncond_branch;
        rob_tag_t        rob_tag;
    } fu_in_t;

    // one data bus broadcast
    typedef struct packed {
        logic            valid;
        rob_tag_t        rob_tag;
        logic [xlen-1:0] value;
        logic            take_branch;
        logic [xlen-1:0] branch_target;
    } cdb_t;

    // result held in a unit, done means waiting for the bus
    typedef struct packed {
        logic            done;
        rob_tag_t        rob_tag;
        logic [xlen-1:0] value;
        logic            take_branch;
        logic [xlen-1:0] branch_target;
    } fu_result_t;

endpackage

// ==== src/imm_decode.sv ====
// immediate decoder, rebuilds the i, s, b, u or j immediate of an instruction
`timescale 1ns/1ps

module imm_decode (
    input  logic [31:0]              inst,
    input  exu_pkg::opb_sel_t        opb_sel,
    output logic [exu_pkg::xlen-1:0] imm
);

    // sign bit is always inst[31]
    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (opb_sel)
            // 12 bit, loads and alu immediates
            exu_pkg::opb_i_imm: imm = {{20{sign}}, inst[31:20]};
            // 12 bit split around rd
            exu_pkg::opb_s_imm: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            // 13 bit, bit 0 implied zero
            exu_pkg::opb_b_imm: imm = {{19{sign}}, sign, inst[7], inst[30:25],
                                       inst[11:8], 1'b0};
            // upper 20 bits, low 12 cleared
            exu_pkg::opb_u_imm: imm = {inst[31:12], 12'h000};
            // 21 bit jump offset
            exu_pkg::opb_j_imm: imm = {{11{sign}}, sign, inst[19:12], inst[20],
                                       inst[30:21], 1'b0};
            // register operand, immediate not used
            default:            imm = '0;
        endcase
    end

endmodule

// ==== src/issue_dispatch.sv ====
// issue dispatcher: four-phase issue port, hands each operation to a free unit
`timescale 1ns/1ps

module issue_dispatch #(
    parameter int NUM_FU = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue_req,
    input  exu_pkg::fu_in_t       issue_op,
    output logic                  issue_ack,
    input  logic [NUM_FU-1:0]     fu_done,
    output logic [NUM_FU-1:0]     fu_valid,
    output exu_pkg::fu_in_t       fu_op
);

    // handshake state
    typedef enum logic {
        st_idle,
        st_ack
    } state_t;

    state_t            state;
    logic [NUM_FU-1:0] free;
    logic [NUM_FU-1:0] pick;
    logic              any_free;
    logic              take;

    // free means nothing held and no pulse in flight
    assign free     = ~fu_done & ~fu_valid;
    assign any_free = |free;

    // lowest free unit, one-hot
    always_comb begin
        logic found;
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (free[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    // request seen with ack low and somewhere to put it
    assign take      = (state == st_idle) && issue_req && any_free;
    assign issue_ack = (state == st_ack);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_idle;
            fu_valid <= '0;
        end else begin
            // valid is a single-cycle pulse
            fu_valid <= take ? pick : '0;
            case (state)
                st_idle: if (take) state <= st_ack;
                // drop ack once the source has dropped req
                st_ack:  if (!issue_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // operation register, shared by all units
    always_ff @(posedge clock) begin
        if (take) begin
            fu_op <= issue_op;
        end
    end

endmodule

// ==== test/exec_cluster_tb.sv ====
// execute cluster testbench with directed tests, a reference model and a cdb monitor
`timescale 1ns/1ps

module exec_cluster_tb;

    // wait limits in cycles
    localparam int ACK_WAIT = 40;
    localparam int CDB_WAIT = 80;

    logic            clock;
    logic            reset;
    logic            issue_req;
    exu_pkg::fu_in_t issue_op;
    logic            issue_ack;
    exu_pkg::cdb_t   cdb;

    logic [31:0]       rand_state   = 32'h57adc365;
    int                cycle_count  = 0;
    int                test_errors  = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    exu_pkg::rob_tag_t next_tag     = '0;
    // every valid bus cycle since reset
    int                bus_count    = 0;
    // bus record indexed by rob tag
    int                seen_count [64];
    int                seen_cycle [64];
    exu_pkg::cdb_t     seen_bus   [64];

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (8)
    ) clock_gen_0 (
        .clock (clock),
        .reset (reset)
    );

    exec_cluster #(
        .NUM_FU (2)
    ) dut0 (
        .clock     (clock),
        .reset     (reset),
        .issue_req (issue_req),
        .issue_op  (issue_op),
        .issue_ack (issue_ack),
        .cdb       (cdb)
    );

    always @(posedge clock) cycle_count <= cycle_count + 1;

    // cdb monitor samples mid-cycle
    always @(negedge clock) begin
        if (reset === 1'b0 && cdb.valid === 1'b1) begin
            bus_count               = bus_count + 1;
            seen_count[cdb.rob_tag] = seen_count[cdb.rob_tag] + 1;
            seen_cycle[cdb.rob_tag] = cycle_count;
            seen_bus[cdb.rob_tag]   = cdb;
        end
    end

    // xorshift32 operand source
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    // scatter an immediate into its instruction format with rs1=x1 rs2=x3 rd=x2
    function automatic logic [31:0] encode(exu_pkg::opb_sel_t sel, logic [31:0] imm,
                                           logic [2:0] f3);
        case (sel)
            exu_pkg::opb_i_imm: return {imm[11:0], 5'd1, f3, 5'd2, 7'h13};
            exu_pkg::opb_s_imm: return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'h23};
            exu_pkg::opb_b_imm: return {imm[12], imm[10:5], 5'd3, 5'd1, f3, imm[4:1],
                                        imm[11], 7'h63};
            exu_pkg::opb_u_imm: return {imm[31:12], 5'd2, 7'h37};
            exu_pkg::opb_j_imm: return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd2, 7'h6f};
            default:            return {7'h00, 5'd3, 5'd1, f3, 5'd2, 7'h33};
        endcase
    endfunction

    // expected broadcast from the encoded immediate value
    function automatic exu_pkg::cdb_t model(exu_pkg::fu_in_t op, logic [31:0] imm);
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   r;
        logic          cond_ok;
        logic          taken;
        exu_pkg::cdb_t e;
        case (op.opa_sel)
            exu_pkg::opa_rs1: a = op.rs1_value;
            exu_pkg::opa_npc: a = op.npc;
            exu_pkg::opa_pc:  a = op.pc;
            default:          a = 32'h0;
        endcase
        b = (op.opb_sel == exu_pkg::opb_rs2) ? op.rs2_value : imm;
        case (op.alu_func)
            exu_pkg::alu_add:  r = a + b;
            exu_pkg::alu_sub:  r = a - b;
            exu_pkg::alu_and:  r = a & b;
            exu_pkg::alu_or:   r = a | b;
            exu_pkg::alu_xor:  r = a ^ b;
            exu_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            exu_pkg::alu_sll:  r = a << b[4:0];
            exu_pkg::alu_srl:  r = a >> b[4:0];
            exu_pkg::alu_sra:  r = $unsigned($signed(a) >>> b[4:0]);
            default:           r = 32'hbadc_0de5;
        endcase
        // compare on the register values with funct3 at inst[14:12]
        case (op.inst[14:12])
            3'b000:  cond_ok = (op.rs1_value == op.rs2_value);
            3'b001:  cond_ok = (op.rs1_value != op.rs2_value);
            3'b100:  cond_ok = ($signed(op.rs1_value) < $signed(op.rs2_value));
            3'b101:  cond_ok = ($signed(op.rs1_value) >= $signed(op.rs2_value));
            3'b110:  cond_ok = (op.rs1_value < op.rs2_value);
            3'b111:  cond_ok = (op.rs1_value >= op.rs2_value);
            default: cond_ok = 1'b0;
        endcase
        taken           = op.uncond_branch || (op.cond_branch && cond_ok);
        e.valid         = 1'b1;
        e.rob_tag       = op.rob_tag;
        e.value         = taken ? op.npc : r;
        e.take_branch   = taken;
        e.branch_target = r;
        return e;
    endfunction

    // new operation takes the next tag and clears its bus record
    function automatic exu_pkg::fu_in_t build_op(exu_pkg::opa_sel_t sa, exu_pkg::opb_sel_t sb,
                                                 exu_pkg::alu_func_t f, logic [31:0] inst,
                                                 logic [31:0] rs1, logic [31:0] rs2,
                                                 logic cond, logic uncond);
        exu_pkg::fu_in_t op;
        op.inst          = inst;
        op.pc            = next_rand() & 32'hffff_fffc;
        op.npc           = op.pc + 32'd4;
        op.rs1_value     = rs1;
        op.rs2_value     = rs2;
        op.opa_sel       = sa;
        op.opb_sel       = sb;
        op.alu_func      = f;
        op.cond_branch   = cond;
        op.uncond_branch = uncond;
        op.rob_tag       = next_tag;
        next_tag         = next_tag + 1'b1;
        seen_count[op.rob_tag] = 0;
        return op;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    // full four-phase exchange
    // ack_cycle is the edge count when ack rose
    task automatic send_op(input exu_pkg::fu_in_t op, output int ack_cycle);
        int waited;
        @(posedge clock);
        issue_req <= 1'b1;
        issue_op  <= op;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (issue_ack !== 1'b1 && waited < ACK_WAIT);
        assert (issue_ack === 1'b1) else begin
            $display("issue_ack never rose for tag %0d", op.rob_tag);
            test_errors++;
        end
        ack_cycle = cycle_count;
        @(posedge clock);
        issue_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (issue_ack !== 1'b0 && waited < ACK_WAIT);
        assert (issue_ack === 1'b0) else begin
            $display("issue_ack stayed high after issue_req dropped, tag %0d", op.rob_tag);
            test_errors++;
        end
    endtask

    task automatic wait_tag(input exu_pkg::rob_tag_t tag, output logic seen);
        int waited;
        waited = 0;
        while (seen_count[tag] == 0 && waited < CDB_WAIT) begin
            @(posedge clock);
            waited++;
        end
        seen = (seen_count[tag] != 0);
        assert (seen) else begin
            $display("tag %0d never appeared on the cdb", tag);
            test_errors++;
        end
    endtask

    task automatic compare_bus(input exu_pkg::cdb_t exp);
        check_hex("cdb.value", exp.value, seen_bus[exp.rob_tag].value);
        check_hex("cdb.take_branch", exp.take_branch, seen_bus[exp.rob_tag].take_branch);
        check_hex("cdb.branch_target", exp.branch_target, seen_bus[exp.rob_tag].branch_target);
    endtask

    // one operation alone in the cluster so latency is fixed at 2
    task automatic run_one(input exu_pkg::opa_sel_t sa, input exu_pkg::opb_sel_t sb,
                           input logic [31:0] imm, input exu_pkg::alu_func_t f,
                           input logic [2:0] f3, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic cond, input logic uncond);
        exu_pkg::fu_in_t op;
        exu_pkg::cdb_t   exp;
        int              ack_cycle;
        logic            seen;
        op  = build_op(sa, sb, f, encode(sb, imm, f3), rs1, rs2, cond, uncond);
        exp = model(op, imm);
        send_op(op, ack_cycle);
        wait_tag(op.rob_tag, seen);
        if (seen) begin
            compare_bus(exp);
            assert (seen_cycle[op.rob_tag] - ack_cycle == 2) else begin
                $display("tag %0d reached the cdb %0d cycles after issue_ack instead of 2",
                         op.rob_tag, seen_cycle[op.rob_tag] - ack_cycle);
                test_errors++;
            end
            // target straight from pc plus the encoded offset
            if ((cond || uncond) && sa == exu_pkg::opa_pc) begin
                check_hex("cdb.branch_target", op.pc + imm, seen_bus[op.rob_tag].branch_target);
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic reset_idle();
        int waited;
        waited = 0;
        @(negedge clock);
        while (reset === 1'b1 && waited < 20) begin
            check_hex("issue_ack", 32'h0, issue_ack);
            check_hex("cdb.valid", 32'h0, cdb.valid);
            @(negedge clock);
            waited++;
        end
        assert (reset === 1'b0) else begin
            $display("reset was never released");
            test_errors++;
        end
        // still idle before the first request
        repeat (3) begin
            check_hex("issue_ack", 32'h0, issue_ack);
            check_hex("cdb.valid", 32'h0, cdb.valid);
            @(negedge clock);
        end
        finish_test("reset state");
    endtask

    task automatic reg_reg_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int f = 0; f < 10; f++) begin
            for (int k = 0; k < 6; k++) begin
                a = next_rand();
                b = next_rand();
                // most negative value and shift amounts above 31
                if (k == 3) begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                if (k == 4) begin
                    a = 32'h8000_0000;
                    b = 32'h0000_003f;
                end
                if (k == 5) b = 32'h0000_0025;
                run_one(exu_pkg::opa_rs1, exu_pkg::opb_rs2, 32'h0, exu_pkg::alu_func_t'(f),
                        3'b000, a, b, 1'b0, 1'b0);
            end
        end
        finish_test("register-register operations");
    endtask

    task automatic operand_select();
        run_one(exu_pkg::opa_pc, exu_pkg::opb_i_imm, 32'hffff_fffb, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_rs1, exu_pkg::opb_i_imm, 32'h0000_07ff, exu_pkg::alu_xor, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_npc, exu_pkg::opb_s_imm, 32'hffff_f800, exu_pkg::alu_add, 3'b010,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_rs1, exu_pkg::opb_s_imm, 32'h0000_0555, exu_pkg::alu_or, 3'b010,
                next_rand(), next_rand(), 1'b0, 1'b0);
        // lui and auipc shapes
        run_one(exu_pkg::opa_zero, exu_pkg::opb_u_imm, 32'hdead_b000, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_pc, exu_pkg::opb_u_imm, 32'h0001_2000, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_pc, exu_pkg::opb_b_imm, 32'hffff_f000, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_zero, exu_pkg::opb_b_imm, 32'h0000_0ffe, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_pc, exu_pkg::opb_j_imm, 32'hfff0_0000, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        run_one(exu_pkg::opa_rs1, exu_pkg::opb_j_imm, 32'h000f_fffe, exu_pkg::alu_sub, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b0);
        finish_test("operand selection");
    endtask

    task automatic branch_outcomes();
        logic [31:0] lhs [5];
        logic [31:0] rhs [5];
        logic [2:0]  f3s [6];
        logic [31:0] imm;
        // equal, both less, both greater, signed and unsigned disagreeing
        lhs = '{32'h5, 32'h1, 32'h2, 32'hffff_ffff, 32'h1};
        rhs = '{32'h5, 32'h2, 32'h1, 32'h1, 32'hffff_ffff};
        f3s = '{exu_pkg::f3_beq, exu_pkg::f3_bne, exu_pkg::f3_blt,
                exu_pkg::f3_bge, exu_pkg::f3_bltu, exu_pkg::f3_bgeu};
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 5; j++) begin
                imm = (j % 2 == 1) ? 32'hffff_fff8 : 32'h0000_0ffe;
                run_one(exu_pkg::opa_pc, exu_pkg::opb_b_imm, imm, exu_pkg::alu_add, f3s[i],
                        lhs[j], rhs[j], 1'b1, 1'b0);
            end
        end
        // reserved funct3 is never taken
        run_one(exu_pkg::opa_pc, exu_pkg::opb_b_imm, 32'h0000_0010, exu_pkg::alu_add, 3'b010,
                32'h7, 32'h7, 1'b1, 1'b0);
        // jal with backward and forward offsets
        run_one(exu_pkg::opa_pc, exu_pkg::opb_j_imm, 32'hffff_fff0, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b1);
        run_one(exu_pkg::opa_pc, exu_pkg::opb_j_imm, 32'h0000_1000, exu_pkg::alu_add, 3'b000,
                next_rand(), next_rand(), 1'b0, 1'b1);
        finish_test("branches");
    endtask

    task automatic back_to_back_issue();
        exu_pkg::fu_in_t op;
        exu_pkg::cdb_t   exp [20];
        int              ack_cycle;
        int              waited;
        int              start_count;
        logic            all_seen;
        start_count = bus_count;
        for (int i = 0; i < 20; i++) begin
            // every fourth one a bne and the rest register ops
            if (i % 4 == 3) begin
                op = build_op(exu_pkg::opa_pc, exu_pkg::opb_b_imm, exu_pkg::alu_add,
                              encode(exu_pkg::opb_b_imm, 32'h10, exu_pkg::f3_bne),
                              next_rand(), next_rand() & 32'h1, 1'b1, 1'b0);
                exp[i] = model(op, 32'h10);
            end else begin
                op = build_op(exu_pkg::opa_rs1, exu_pkg::opb_rs2, exu_pkg::alu_func_t'(i % 10),
                              encode(exu_pkg::opb_rs2, 32'h0, 3'b000),
                              next_rand(), next_rand(), 1'b0, 1'b0);
                exp[i] = model(op, 32'h0);
            end
            send_op(op, ack_cycle);
        end
        waited = 0;
        do begin
            all_seen = 1'b1;
            for (int i = 0; i < 20; i++) begin
                if (seen_count[exp[i].rob_tag] == 0) all_seen = 1'b0;
            end
            if (!all_seen) @(posedge clock);
            waited++;
        end while (!all_seen && waited < CDB_WAIT);
        assert (all_seen) else begin
            $display("not every contention tag reached the cdb");
            test_errors++;
        end
        // settle so a late duplicate would be counted
        repeat (4) @(posedge clock);
        // each operation owns a bus cycle of its own
        assert (bus_count - start_count == 20) else begin
            $display("the cdb carried %0d broadcast cycles for 20 operations",
                     bus_count - start_count);
            test_errors++;
        end
        for (int i = 0; i < 20; i++) begin
            assert (seen_count[exp[i].rob_tag] == 1) else begin
                $display("tag %0d was broadcast %0d times", exp[i].rob_tag,
                         seen_count[exp[i].rob_tag]);
                test_errors++;
            end
            if (seen_count[exp[i].rob_tag] != 0) compare_bus(exp[i]);
        end
        finish_test("contention");
    endtask

    initial begin
        issue_req = 1'b0;
        issue_op  = '0;
        reset_idle();
        reg_reg_ops();
        operand_select();
        branch_outcomes();
        back_to_back_issue();
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset generator, free-running clock with a timed reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);

    // first rising edge half a period in
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // reset held over the first rising edges, released on an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule
